/* flist.f */
+incdir+hdl
hdl/op_pkg.sv
hdl/pkt_pkg.sv
hdl/gaxi_regslice.sv
hdl/beat_counter.sv
hdl/pkt_ctrl_fsm.sv
hdl/payload_xform.sv
hdl/pkt_engine_top.sv
dv/pkt_engine_assert.sv
dv/pkt_engine_tb.sv

/* Makefile */
TOOL     := verilator
TOP      := pkt_engine_tb
FLIST    := flist.f
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
OBJ_DIR  := obj_dir
PASS_MSG := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/pkt_engine_tb.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module pkt_engine_tb
    import op_pkg::*;
    import pkt_pkg::*;
;

    localparam int NUM_ROWS       = 8;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int PIPE_LATENCY   = 3;

    // One packet: op, length, argument, first payload word
    typedef struct packed {
        op_e                       op;
        logic [`STREAM_LEN_W-1:0]  len;
        logic [`STREAM_ARG_W-1:0]  arg;
        logic [`STREAM_DATA_W-1:0] seed;
    } row_t;

    logic                      axi_aclk;
    logic                      axi_aresetn;
    logic                      s_valid;
    logic                      s_ready;
    logic [`STREAM_DATA_W-1:0] s_data;
    logic                      m_valid;
    logic                      m_ready;
    logic [`STREAM_DATA_W-1:0] m_data;
    logic                      m_last;

    row_t                    rows [NUM_ROWS];
    // Expected beats, last in the top bit
    logic [`STREAM_DATA_W:0] exp_q [$];
    int                      exp_pkt_q [$];
    // Input transfer cycle of each forwarded payload beat
    int                      lat_q [$];
    int                      cycle;
    int                      errors;
    int                      beats_seen;
    logic                    stall_en;
    logic                    lat_check;
    logic                    timed_out;

    pkt_engine_top u_dut (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_data      (s_data),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_data      (m_data),
        .m_last      (m_last)
    );

    // --------------------
    // Clock and sink
    // --------------------

    always #5 axi_aclk = ~axi_aclk;

    always @(posedge axi_aclk) begin
        cycle <= cycle + 1;
    end

    // Sink stalls about 30 percent of cycles in the back-pressure phase
    always @(negedge axi_aclk) begin
        if (stall_en) begin
            m_ready = (($urandom % 100) >= 30);
        end else begin
            m_ready = 1'b1;
        end
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [`STREAM_DATA_W-1:0] model_xform(
        input op_e                       op,
        input logic [`STREAM_ARG_W-1:0]  arg,
        input logic [`STREAM_DATA_W-1:0] data
    );
        case (op)
            OP_ADD:  return data + {16'h0000, arg};
            OP_XOR:  return data ^ {arg, arg};
            default: return data;
        endcase
    endfunction

    function automatic string op_label(input op_e op);
        case (op)
            OP_PASS: return "PASS";
            OP_ADD:  return "ADD";
            OP_XOR:  return "XOR";
            default: return "DROP";
        endcase
    endfunction

    // --------------------
    // Input driver
    // --------------------

    // Holds s_valid until the slice takes the word, leaves it high on return
    task automatic send_word(input logic [`STREAM_DATA_W-1:0] word, input logic track);
        int waited;
        waited  = 0;
        s_valid = 1'b1;
        s_data  = word;
        @(posedge axi_aclk);
        while (!s_ready && (waited < TIMEOUT_CYCLES)) begin
            waited++;
            @(posedge axi_aclk);
        end
        if (!s_ready) begin
            $display("Timeout: input stalled, s_ready stayed low for %0d cycles",
                     TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end else if (track) begin
            lat_q.push_back(cycle);
        end
        @(negedge axi_aclk);
    endtask

    task automatic send_packet(input int idx, input logic track);
        stream_word_u hdr_word;
        row_t         row;
        int           n_beats;
        logic         last_bit;
        row     = rows[idx];
        n_beats = int'(row.len);
        hdr_word.hdr.op   = row.op;
        hdr_word.hdr.rsvd = '0;
        hdr_word.hdr.len  = row.len;
        hdr_word.hdr.arg  = row.arg;
        // Expected output, nothing for DROP
        if (row.op != OP_DROP) begin
            for (int i = 0; i < n_beats; i++) begin
                last_bit = (i == n_beats - 1);
                exp_q.push_back({last_bit, model_xform(row.op, row.arg, row.seed + 32'(i))});
                exp_pkt_q.push_back(idx);
            end
        end
        send_word(hdr_word.payload, 1'b0);
        for (int i = 0; i < n_beats; i++) begin
            if (!timed_out) begin
                send_word(row.seed + 32'(i), track && (row.op != OP_DROP));
            end
        end
        s_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < TIMEOUT_CYCLES)) begin
            waited++;
            @(negedge axi_aclk);
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: output stalled with %0d beats still expected", exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------

    always @(posedge axi_aclk) begin : out_monitor
        logic [`STREAM_DATA_W:0] exp_beat;
        int                      exp_pkt;
        int                      in_cycle;
        if (!axi_aresetn && m_valid && m_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("[ERROR] %0t ns: unexpected output beat %h", $time, m_data);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_beat = exp_q.pop_front();
                exp_pkt  = exp_pkt_q.pop_front();
                beats_seen++;
                assert (m_data == exp_beat[`STREAM_DATA_W-1:0]) else begin
                    $display("[ERROR] %0t ns: packet %0d data %h, expected %h",
                             $time, exp_pkt, m_data, exp_beat[`STREAM_DATA_W-1:0]);
                    errors++;
                end
                assert (m_last == exp_beat[`STREAM_DATA_W]) else begin
                    $display("[ERROR] %0t ns: packet %0d last %b, expected %b",
                             $time, exp_pkt, m_last, exp_beat[`STREAM_DATA_W]);
                    errors++;
                end
                // Beat leaves exactly three edges after it entered
                if (lat_check && (lat_q.size() != 0)) begin
                    in_cycle = lat_q.pop_front();
                    assert ((cycle - in_cycle) == PIPE_LATENCY) else begin
                        $display("[ERROR] %0t ns: packet %0d latency %0d cycles, expected %0d",
                                 $time, exp_pkt, cycle - in_cycle, PIPE_LATENCY);
                        errors++;
                    end
                end
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int phase;
        int err_before;
        int beats_before;
        int packets_done;
        axi_aclk     = 1'b0;
        axi_aresetn  = 1'b1;
        s_valid      = 1'b0;
        s_data       = '0;
        m_ready      = 1'b1;
        cycle        = 0;
        errors       = 0;
        beats_seen   = 0;
        packets_done = 0;
        stall_en     = 1'b0;
        lat_check    = 1'b0;
        timed_out    = 1'b0;
        void'($urandom(22));

        // ADD row wraps past 2^32, rows 3 and 4 emit nothing
        rows[0] = '{OP_PASS, 8'd4, 16'h0000, 32'h1000_0000};
        rows[1] = '{OP_ADD,  8'd3, 16'h0010, 32'hFFFF_FFF0};
        rows[2] = '{OP_XOR,  8'd5, 16'hA5C3, 32'h1234_5678};
        rows[3] = '{OP_DROP, 8'd3, 16'h0000, 32'h0BAD_0000};
        rows[4] = '{OP_PASS, 8'd0, 16'h0000, 32'h0000_0000};
        rows[5] = '{OP_ADD,  8'd2, 16'h1234, 32'h0000_0100};
        rows[6] = '{OP_XOR,  8'd1, 16'hFFFF, 32'h5555_AAAA};
        rows[7] = '{OP_PASS, 8'd6, 16'h0000, 32'h7000_0000};

        // Reset held for four cycles
        repeat (4) @(negedge axi_aclk);
        axi_aresetn = 1'b0;
        @(negedge axi_aclk);
        err_before = errors;
        assert (!m_valid) else begin
            $display("[ERROR] %0t ns: m_valid high after reset", $time);
            errors++;
        end
        assert (s_ready) else begin
            $display("[ERROR] %0t ns: s_ready low after reset", $time);
            errors++;
        end
        $display("reset: %s", (errors == err_before) ? "ok" : "FAIL");

        // Phase 1 free-flowing with latency check, phase 2 random stalls
        for (phase = 1; phase <= 2; phase++) begin
            // Pipeline is empty here
            @(posedge axi_aclk);
            stall_en  = (phase == 2);
            lat_check = (phase == 1);
            @(negedge axi_aclk);
            for (int idx = 0; (idx < NUM_ROWS) && !timed_out; idx++) begin
                err_before   = errors;
                beats_before = beats_seen;
                send_packet(idx, lat_check);
                if (!timed_out) begin
                    wait_drain();
                end
                packets_done++;
                $display("phase %0d packet %0d %s len %0d: %0d beats, %s",
                         phase, idx, op_label(rows[idx].op), rows[idx].len,
                         beats_seen - beats_before,
                         (errors == err_before && !timed_out) ? "ok" : "FAIL");
            end
        end

        // Quiet window, any stray beat is flagged by the monitor
        if (!timed_out) begin
            repeat (10) @(negedge axi_aclk);
        end

        $display("Summary: %0d packets, %0d beats checked, %0d errors",
                 packets_done, beats_seen, errors);
        if (!timed_out && (errors == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* dv/pkt_engine_assert.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module pkt_engine_assert (
    input logic                      axi_aclk,
    input logic                      axi_aresetn,
    input logic                      m_valid,
    input logic                      m_ready,
    input logic [`STREAM_DATA_W-1:0] m_data,
    input logic                      m_last
);

    // --------------------
    // Output stream rules
    // --------------------

    // Stalled beat keeps valid, data and last
    a_hold_stalled: assert property (
        @(posedge axi_aclk) disable iff (axi_aresetn)
        (m_valid && !m_ready) |=> (m_valid && $stable({m_last, m_data}))
    ) else $error("output beat changed while stalled");

    // Output slice empty once reset has been seen
    a_reset_empty: assert property (
        @(posedge axi_aclk)
        axi_aresetn |=> !m_valid
    ) else $error("m_valid high in the cycle after reset");

    // Last only on a presented beat
    a_last_valid: assert property (
        @(posedge axi_aclk) disable iff (axi_aresetn)
        m_last |-> m_valid
    ) else $error("m_last high without m_valid");

endmodule

bind pkt_engine_top pkt_engine_assert u_assert (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_data      (m_data),
    .m_last      (m_last)
);

/* hdl/pkt_engine_top.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module pkt_engine_top
    import op_pkg::*;
(
    input  logic                      axi_aclk,
    input  logic                      axi_aresetn,

    // Input stream carrying headers and payload
    input  logic                      s_valid,
    output logic                      s_ready,
    input  logic [`STREAM_DATA_W-1:0] s_data,

    // Output stream with payload only
    output logic                      m_valid,
    input  logic                      m_ready,
    output logic [`STREAM_DATA_W-1:0] m_data,
    output logic                      m_last
);

    // --------------------
    // Internal streams
    // --------------------

    // Input slice to FSM
    logic                      in_valid;
    logic                      in_ready;
    logic [`STREAM_DATA_W-1:0] in_data;

    // FSM to transform
    logic                      x_valid;
    logic                      x_ready;
    logic [`STREAM_DATA_W-1:0] x_data;
    logic                      x_last;
    op_e                       op;
    logic [`STREAM_ARG_W-1:0]  arg;

    // Counter handshake
    logic                      cnt_load;
    logic [`STREAM_LEN_W-1:0]  cnt_len;
    logic                      cnt_dec;
    logic                      cnt_last;

    // Transform to output slice with last on top
    logic                      y_valid;
    logic                      y_ready;
    logic [`STREAM_DATA_W:0]   y_data;

    // Output slice word with last on top
    logic [`STREAM_DATA_W:0]   m_beat;

    // --------------------
    // Pipeline
    // --------------------

    gaxi_regslice #(.DATA_WIDTH(`STREAM_DATA_W)) u_in_slice (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_valid    (s_valid),
        .wr_ready    (s_ready),
        .wr_data     (s_data),
        .rd_valid    (in_valid),
        .rd_ready    (in_ready),
        .rd_data     (in_data),
        .count       (),
        .rd_count    ()
    );

    pkt_ctrl_fsm u_ctrl (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .x_valid     (x_valid),
        .x_data      (x_data),
        .x_last      (x_last),
        .x_ready     (x_ready),
        .op          (op),
        .arg         (arg),
        .cnt_load    (cnt_load),
        .cnt_len     (cnt_len),
        .cnt_dec     (cnt_dec),
        .cnt_last    (cnt_last)
    );

    beat_counter u_cnt (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .load        (cnt_load),
        .len         (cnt_len),
        .dec         (cnt_dec),
        .last        (cnt_last)
    );

    payload_xform u_xform (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .x_valid     (x_valid),
        .x_data      (x_data),
        .x_last      (x_last),
        .x_ready     (x_ready),
        .op          (op),
        .arg         (arg),
        .y_valid     (y_valid),
        .y_data      (y_data),
        .y_ready     (y_ready)
    );

    // Data and last share one 33-bit slice
    gaxi_regslice #(.DATA_WIDTH(`STREAM_DATA_W + 1)) u_out_slice (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_valid    (y_valid),
        .wr_ready    (y_ready),
        .wr_data     (y_data),
        .rd_valid    (m_valid),
        .rd_ready    (m_ready),
        .rd_data     (m_beat),
        .count       (),
        .rd_count    ()
    );

    // Last shows only on a presented beat
    assign m_data = m_beat[`STREAM_DATA_W-1:0];
    assign m_last = m_valid && m_beat[`STREAM_DATA_W];

endmodule

/* hdl/payload_xform.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module payload_xform
    import op_pkg::*;
(
    input  logic                      axi_aclk,
    input  logic                      axi_aresetn,

    // Payload beats from the FSM
    input  logic                      x_valid,
    input  logic [`STREAM_DATA_W-1:0] x_data,
    input  logic                      x_last,
    output logic                      x_ready,

    // Operation for the current packet
    input  op_e                       op,
    input  logic [`STREAM_ARG_W-1:0]  arg,

    // Result toward the output slice, last in the top bit
    output logic                      y_valid,
    output logic [`STREAM_DATA_W:0]   y_data,
    input  logic                      y_ready
);

    logic                      res_valid;
    logic [`STREAM_DATA_W-1:0] res_data;
    logic                      res_last;
    logic [`STREAM_DATA_W-1:0] calc;
    logic                      x_xfer;

    // --------------------
    // Operation
    // --------------------

    always_comb begin
        case (op)
            // Wraps modulo 2^32
            OP_ADD:  calc = x_data + {{(`STREAM_DATA_W - `STREAM_ARG_W){1'b0}}, arg};
            // Argument doubled into both halves
            OP_XOR:  calc = x_data ^ {arg, arg};
            // PASS, and DROP which never reaches here
            default: calc = x_data;
        endcase
    end

    // --------------------
    // Output register
    // --------------------

    // Same elastic rule as the slices
    assign x_ready = !res_valid || y_ready;
    assign x_xfer  = x_valid && x_ready;

    always_ff @(posedge axi_aclk) begin
        if (axi_aresetn) begin
            res_valid <= 1'b0;
        end else if (x_xfer) begin
            res_valid <= 1'b1;
        end else if (y_ready) begin
            // Drained, nothing new behind it
            res_valid <= 1'b0;
        end
    end

    // Result and last captured together
    always_ff @(posedge axi_aclk) begin
        if (x_xfer) begin
            res_data <= calc;
            res_last <= x_last;
        end
    end

    assign y_valid = res_valid;
    assign y_data  = {res_last, res_data};

endmodule

/* hdl/pkt_ctrl_fsm.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module pkt_ctrl_fsm
    import op_pkg::*;
    import pkt_pkg::*;
(
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,

    // From the input slice
    input  logic                     in_valid,
    input  logic [`STREAM_DATA_W-1:0] in_data,
    output logic                     in_ready,

    // Payload beats toward the transform
    output logic                     x_valid,
    output logic [`STREAM_DATA_W-1:0] x_data,
    output logic                     x_last,
    input  logic                     x_ready,

    // Operation held for the current packet
    output op_e                      op,
    output logic [`STREAM_ARG_W-1:0] arg,

    // Beat counter control
    output logic                     cnt_load,
    output logic [`STREAM_LEN_W-1:0] cnt_len,
    output logic                     cnt_dec,
    input  logic                     cnt_last
);

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } state_e;

    state_e       state;
    state_e       state_nxt;
    stream_word_u word;
    logic         hdr_take;
    logic         drop;

    // --------------------
    // Word decode
    // --------------------

    assign word = in_data;

    // Header fields are only meaningful in IDLE
    assign cnt_len  = word.hdr.len;
    assign hdr_take = (state == ST_IDLE) && in_valid;

    // Payload view
    assign x_data = word.payload;
    assign x_last = cnt_last;

    // Current packet is being discarded
    assign drop = (op == OP_DROP);

    // --------------------
    // Steering
    // --------------------

    always_comb begin
        in_ready  = 1'b1;
        x_valid   = 1'b0;
        cnt_load  = 1'b0;
        cnt_dec   = 1'b0;
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // Every word here is a header and is always accepted
                cnt_load = in_valid;
                if (in_valid && (word.hdr.len != '0)) begin
                    state_nxt = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (!drop) begin
                    // Follow the transform's back-pressure
                    in_ready = x_ready;
                    x_valid  = in_valid;
                end
                cnt_dec = in_valid && in_ready;
                // Final beat closes the packet
                if (cnt_dec && cnt_last) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // --------------------
    // State and held op
    // --------------------

    always_ff @(posedge axi_aclk) begin
        if (axi_aresetn) begin
            state <= ST_IDLE;
            op    <= OP_PASS;
        end else begin
            state <= state_nxt;
            if (hdr_take) begin
                op <= word.hdr.op;
            end
        end
    end

    // Argument travels with op
    always_ff @(posedge axi_aclk) begin
        if (hdr_take) begin
            arg <= word.hdr.arg;
        end
    end

endmodule

/* hdl/beat_counter.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module beat_counter (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,

    // Header length, taken when load is high
    input  logic                     load,
    input  logic [`STREAM_LEN_W-1:0] len,

    // One payload beat consumed
    input  logic                     dec,

    // One beat left in the packet
    output logic                     last
);

    localparam logic [`STREAM_LEN_W-1:0] ONE_BEAT = 1;

    // --------------------
    // Beats remaining
    // --------------------

    logic [`STREAM_LEN_W-1:0] remain;

    always_ff @(posedge axi_aclk) begin
        if (axi_aresetn) begin
            remain <= '0;
        end else if (load) begin
            // New header, zero length leaves it at 0
            remain <= len;
        end else if (dec && (remain != '0)) begin
            // Saturate at zero
            remain <= remain - ONE_BEAT;
        end
    end

    // --------------------
    // Last-beat flag
    // --------------------

    // Combinational from the count, so the FSM sees it with the beat itself
    assign last = (remain == ONE_BEAT);

endmodule

/* hdl/gaxi_regslice.sv */
`timescale 1ns/10ps

`include "stream_cfg.svh"

module gaxi_regslice #(
    parameter int DATA_WIDTH = `STREAM_DATA_W
) (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,

    // Upstream side
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  logic [DATA_WIDTH-1:0] wr_data,

    // Downstream side
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output logic [DATA_WIDTH-1:0] rd_data,

    // Occupancy, only ever 0 or 1
    output logic [3:0]            count,
    output logic [3:0]            rd_count
);

    // --------------------
    // Storage
    // --------------------

    logic                  held_valid;
    logic [DATA_WIDTH-1:0] held_data;
    logic                  wr_xfer;
    logic                  rd_xfer;

    assign wr_xfer = wr_valid && wr_ready;
    assign rd_xfer = rd_valid && rd_ready;

    // Take a beat when empty, or when the held one leaves this cycle
    assign wr_ready = !held_valid || rd_ready;

    assign rd_valid = held_valid;
    assign rd_data  = held_data;

    // --------------------
    // Occupancy flag
    // --------------------

    always_ff @(posedge axi_aclk) begin
        if (axi_aresetn) begin
            held_valid <= 1'b0;
        end else if (wr_xfer) begin
            // Fill, or refill while draining
            held_valid <= 1'b1;
        end else if (rd_xfer) begin
            held_valid <= 1'b0;
        end
    end

    // Data only moves on an accepted write
    always_ff @(posedge axi_aclk) begin
        if (wr_xfer) begin
            held_data <= wr_data;
        end
    end

    // Status mirrors
    assign count    = {3'b000, held_valid};
    assign rd_count = count;

endmodule

/* hdl/pkt_pkg.sv */
`include "stream_cfg.svh"

// Word formats seen on the input stream
package pkt_pkg;

    import op_pkg::*;

    // --------------------
    // Header layout
    // --------------------

    // MSB first: op, reserved, len, arg
    typedef struct packed {
        op_e                      op;
        // Unused, ignored on decode
        logic [5:0]               rsvd;
        // Payload beats after this header
        logic [`STREAM_LEN_W-1:0] len;
        // Operand for ADD and XOR
        logic [`STREAM_ARG_W-1:0] arg;
    } hdr_t;

    // --------------------
    // Word views
    // --------------------

    // Same 32 bits read as header in IDLE, as payload otherwise
    typedef union packed {
        hdr_t                      hdr;
        logic [`STREAM_DATA_W-1:0] payload;
    } stream_word_u;

endpackage

/* hdl/op_pkg.sv */
`include "stream_cfg.svh"

// Operation codes carried in the header top bits
package op_pkg;

    // --------------------
    // Payload operations
    // --------------------

    // Two-bit code, sits in header bits 31:30
    typedef enum logic [1:0] {
        // Forward payload untouched
        OP_PASS = 2'd0,
        // Add zero-extended argument
        OP_ADD  = 2'd1,
        // Xor argument doubled across both halves
        OP_XOR  = 2'd2,
        // Swallow payload, emit nothing
        OP_DROP = 2'd3
    } op_e;

endpackage

/* hdl/stream_cfg.svh */
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// --------------------
// Stream geometry
// --------------------

// One stream word, header or payload
`define STREAM_DATA_W 32

// Header payload length field
`define STREAM_LEN_W 8

// Header argument field, low half of the word
`define STREAM_ARG_W 16

`endif
